// File: all.f
+incdir+verilog
verilog/triviumPkg.sv
verilog/bufferPkg.sv
verilog/triviumCore.sv
verilog/streamEngine.sv
verilog/bufferArbiter.sv
verilog/dataBuffer.sv
verilog/cipherTop.sv
dv/tbCipher.sv

// File: run.sh
#!/bin/sh
# Build and run the cipher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tbCipher

if ./obj_dir/VtbCipher | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// File: dv/tbCipher.sv
`include "trivium_defines.svh"

module tbCipher;

    localparam int TIMEOUT = 20000;   // Cycles allowed per wait

    logic              CLK;
    logic              RSTn;
    logic              hostWrite;
    logic              hostRead;
    bufferPkg::addrT   hostAddr;
    bufferPkg::wordT   hostWdata;
    bufferPkg::wordT   hostRdata;
    logic              hostRvalid;
    logic              jobStart;
    logic              jobEngine;
    logic [`KEY_W-1:0] jobKey;
    logic [`KEY_W-1:0] jobIv;
    bufferPkg::addrT   jobBase;
    logic [`ADDR_W:0]  jobWords;
    logic              busy0;
    logic              busy1;
    logic              done0;
    logic              done1;

    integer            seed;
    bufferPkg::wordT   shadow [`BUF_DEPTH];    // Expected buffer contents
    bufferPkg::wordT   plain [`BUF_DEPTH];     // Plaintext kept for the round trip
    bufferPkg::wordT   ksModel [`BUF_DEPTH];   // Keystream words of the last model run
    logic              seen0;
    logic              seen1;

    cipherTop i_dut (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .hostWrite  (hostWrite),
        .hostRead   (hostRead),
        .hostAddr   (hostAddr),
        .hostWdata  (hostWdata),
        .hostRdata  (hostRdata),
        .hostRvalid (hostRvalid),
        .jobStart   (jobStart),
        .jobEngine  (jobEngine),
        .jobKey     (jobKey),
        .jobIv      (jobIv),
        .jobBase    (jobBase),
        .jobWords   (jobWords),
        .busy0      (busy0),
        .busy1      (busy1),
        .done0      (done0),
        .done1      (done1)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic int randBelow(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    function automatic logic [`KEY_W-1:0] randKey();
        int a;
        int b;
        int c;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        return {a, b, c[15:0]};
    endfunction

    task automatic checkWord(input string name, input bufferPkg::wordT got,
                             input bufferPkg::wordT exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // One Trivium round in spec numbering, s1 is the first bit of register A
    task automatic advanceState(inout logic [288:1] s, output logic z);
        logic t1;
        logic t2;
        logic t3;
        t1 = s[66] ^ s[93];
        t2 = s[162] ^ s[177];
        t3 = s[243] ^ s[288];
        z  = t1 ^ t2 ^ t3;
        t1 = t1 ^ (s[91] & s[92]) ^ s[171];
        t2 = t2 ^ (s[175] & s[176]) ^ s[264];
        t3 = t3 ^ (s[286] & s[287]) ^ s[69];
        s[93:1]    = {s[92:1], t3};
        s[177:94]  = {s[176:94], t1};
        s[288:178] = {s[287:178], t2};
    endtask

    task automatic computeKeystream(input logic [`KEY_W-1:0] key,
                                    input logic [`KEY_W-1:0] iv, input int nWords);
        logic [288:1]    s;
        logic            z;
        bufferPkg::wordT word;
        s          = '0;
        s[80:1]    = {<<8{key}};   // Byte reversed key, K1 in s1
        s[173:94]  = {<<8{iv}};
        s[288:286] = 3'b111;
        repeat (`WARMUP_ROUNDS) advanceState(s, z);
        for (int w = 0; w < nWords; w++) begin
            word = '0;
            for (int b = 0; b < `WORD_W; b++) begin
                advanceState(s, z);
                word = word | (bufferPkg::wordT'(z) << b);
            end
            ksModel[bufferPkg::addrT'(w)] = word;
        end
    endtask

    task automatic nextCycle();
        @(posedge CLK);
        #1;
    endtask

    // Checks the host read of the cycle that just ended and tracks done pulses
    task automatic stepCycle();
        logic            wasRead;
        bufferPkg::addrT wasAddr;
        wasRead = hostRead;
        wasAddr = hostAddr;
        nextCycle();
        hostRead  = 1'b0;
        hostWrite = 1'b0;
        jobStart  = 1'b0;
        checkBit("hostRvalid", hostRvalid, wasRead);
        if (wasRead) begin
            checkWord("hostRdata", hostRdata, shadow[wasAddr]);
        end
        if (done0) begin
            checkBit("busy0", busy0, 1'b0);   // Busy drops with done
            seen0 = 1'b1;
        end
        if (done1) begin
            checkBit("busy1", busy1, 1'b0);
            seen1 = 1'b1;
        end
    endtask

    task automatic hostWriteWord(input int addr, input bufferPkg::wordT data);
        hostWrite = 1'b1;
        hostAddr  = bufferPkg::addrT'(addr);
        hostWdata = data;
        shadow[bufferPkg::addrT'(addr)] = data;
        stepCycle();
    endtask

    task automatic hostReadWord(input int addr);
        hostRead = 1'b1;
        hostAddr = bufferPkg::addrT'(addr);
        stepCycle();
    endtask

    task automatic verifyRange(input int base, input int words);
        for (int i = 0; i < words; i++) begin
            hostReadWord(base + i);
        end
    endtask

    task automatic startJob(input logic eng, input logic [`KEY_W-1:0] key,
                            input logic [`KEY_W-1:0] iv, input int base, input int words);
        jobStart  = 1'b1;
        jobEngine = eng;
        jobKey    = key;
        jobIv     = iv;
        jobBase   = bufferPkg::addrT'(base);
        jobWords  = (`ADDR_W + 1)'(words);
        stepCycle();
        if (eng) begin
            checkBit("busy1", busy1, 1'b1);
        end else begin
            checkBit("busy0", busy0, 1'b1);
        end
    endtask

    // Waits for the wanted done pulses, optionally with host reads at 56..63
    task automatic waitJobs(input logic want0, input logic want1, input logic traffic);
        int cycles;
        seen0  = 1'b0;
        seen1  = 1'b0;
        cycles = 0;
        while ((want0 && !seen0) || (want1 && !seen1)) begin
            if (cycles == TIMEOUT) begin
                $display("Timeout: an engine job never signalled done");
                $display("TEST FAILED");
                $fatal(1);
            end
            if (traffic && randBelow(3) == 0) begin
                hostRead = 1'b1;
                hostAddr = bufferPkg::addrT'(56 + randBelow(8));
            end
            stepCycle();
            cycles++;
        end
    endtask

    task automatic applyJob(input logic [`KEY_W-1:0] key, input logic [`KEY_W-1:0] iv,
                            input int base, input int words);
        computeKeystream(key, iv, words);
        for (int i = 0; i < words; i++) begin
            shadow[bufferPkg::addrT'(base + i)] ^= ksModel[bufferPkg::addrT'(i)];
        end
    endtask

    initial begin
        logic [`KEY_W-1:0] keyA;
        logic [`KEY_W-1:0] ivA;
        logic [`KEY_W-1:0] keyB;
        logic [`KEY_W-1:0] ivB;
        int                base0;
        int                words0;
        int                base1;
        int                words1;
        int                op;
        seed      = 32'h8665_00a1;
        RSTn      = 1'b0;
        hostWrite = 1'b0;
        hostRead  = 1'b0;
        hostAddr  = '0;
        hostWdata = '0;
        jobStart  = 1'b0;
        jobEngine = 1'b0;
        jobKey    = '0;
        jobIv     = '0;
        jobBase   = '0;
        jobWords  = '0;
        repeat (5) @(posedge CLK);
        #1;
        RSTn = 1'b1;
        checkBit("busy0", busy0, 1'b0);
        checkBit("busy1", busy1, 1'b0);
        checkBit("done0", done0, 1'b0);
        checkBit("done1", done1, 1'b0);
        checkBit("hostRvalid", hostRvalid, 1'b0);

        for (int a = 0; a < `BUF_DEPTH; a++) begin
            hostWriteWord(a, $random(seed));
        end
        for (int n = 0; n < 48; n++) begin
            op = randBelow(3);
            if (op == 0) begin
                hostWriteWord(randBelow(`BUF_DEPTH), $random(seed));
            end else if (op == 1) begin
                hostReadWord(randBelow(`BUF_DEPTH));
            end else begin
                stepCycle();   // Idle, hostRvalid must stay low
            end
        end

        // One engine alone, then the same job again on the other engine
        base0  = randBelow(32);
        words0 = 1 + randBelow(24);
        keyA   = randKey();
        ivA    = randKey();
        for (int i = 0; i < words0; i++) begin
            plain[bufferPkg::addrT'(base0 + i)] = shadow[bufferPkg::addrT'(base0 + i)];
        end
        startJob(1'b0, keyA, ivA, base0, words0);
        waitJobs(1'b1, 1'b0, 1'b0);
        applyJob(keyA, ivA, base0, words0);
        verifyRange(base0, words0);
        startJob(1'b1, keyA, ivA, base0, words0);
        waitJobs(1'b0, 1'b1, 1'b0);
        for (int i = 0; i < words0; i++) begin
            shadow[bufferPkg::addrT'(base0 + i)] = plain[bufferPkg::addrT'(base0 + i)];
        end
        verifyRange(base0, words0);

        // Both engines on disjoint regions with host reads in between
        base0  = randBelow(8);
        words0 = 4 + randBelow(13);
        base1  = 32 + randBelow(8);
        words1 = 4 + randBelow(13);
        keyA   = randKey();
        ivA    = randKey();
        keyB   = randKey();
        ivB    = randKey();
        startJob(1'b0, keyA, ivA, base0, words0);
        startJob(1'b1, keyB, ivB, base1, words1);
        waitJobs(1'b1, 1'b1, 1'b1);
        applyJob(keyA, ivA, base0, words0);
        applyJob(keyB, ivB, base1, words1);
        verifyRange(base0, words0);
        verifyRange(base1, words1);

        // Second start while busy must not disturb the running job
        base1  = 40 + randBelow(8);
        words1 = 2 + randBelow(8);
        keyA   = randKey();
        ivA    = randKey();
        startJob(1'b1, keyA, ivA, base1, words1);
        repeat (4) stepCycle();
        startJob(1'b1, ~keyA, ivA, base1, words1);
        waitJobs(1'b0, 1'b1, 1'b0);
        applyJob(keyA, ivA, base1, words1);
        verifyRange(base1, words1);
        checkBit("busy1", busy1, 1'b0);

        verifyRange(0, `BUF_DEPTH);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: verilog/cipherTop.sv
`include "trivium_defines.svh"

module cipherTop (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              hostWrite,
    input  logic              hostRead,
    input  bufferPkg::addrT   hostAddr,
    input  bufferPkg::wordT   hostWdata,
    output bufferPkg::wordT   hostRdata,
    output logic              hostRvalid,
    input  logic              jobStart,
    input  logic              jobEngine,   // 0 or 1
    input  logic [`KEY_W-1:0] jobKey,
    input  logic [`KEY_W-1:0] jobIv,
    input  bufferPkg::addrT   jobBase,
    input  logic [`ADDR_W:0]  jobWords,
    output logic              busy0,
    output logic              busy1,
    output logic              done0,
    output logic              done1
);

    logic            start0;
    logic            start1;
    logic            req0;
    logic            req1;
    logic            we0;
    logic            we1;
    logic            gnt0;
    logic            gnt1;
    bufferPkg::addrT addr0;
    bufferPkg::addrT addr1;
    bufferPkg::wordT wdata0;
    bufferPkg::wordT wdata1;
    logic            memEn;
    logic            memWe;
    bufferPkg::addrT memAddr;
    bufferPkg::wordT memWdata;
    bufferPkg::wordT memRdata;

    assign start0    = jobStart && !jobEngine;
    assign start1    = jobStart && jobEngine;
    assign hostRdata = memRdata;   // Read data shared by all requesters

    streamEngine engine0 (
        .CLK   (CLK),
        .RSTn  (RSTn),
        .start (start0),
        .key   (jobKey),
        .iv    (jobIv),
        .base  (jobBase),
        .words (jobWords),
        .gnt   (gnt0),
        .rdata (memRdata),
        .req   (req0),
        .we    (we0),
        .addr  (addr0),
        .wdata (wdata0),
        .busy  (busy0),
        .done  (done0)
    );

    streamEngine engine1 (
        .CLK   (CLK),
        .RSTn  (RSTn),
        .start (start1),
        .key   (jobKey),
        .iv    (jobIv),
        .base  (jobBase),
        .words (jobWords),
        .gnt   (gnt1),
        .rdata (memRdata),
        .req   (req1),
        .we    (we1),
        .addr  (addr1),
        .wdata (wdata1),
        .busy  (busy1),
        .done  (done1)
    );

    bufferArbiter arbiter (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .hostWrite  (hostWrite),
        .hostRead   (hostRead),
        .hostAddr   (hostAddr),
        .hostWdata  (hostWdata),
        .req0       (req0),
        .we0        (we0),
        .addr0      (addr0),
        .wdata0     (wdata0),
        .req1       (req1),
        .we1        (we1),
        .addr1      (addr1),
        .wdata1     (wdata1),
        .gnt0       (gnt0),
        .gnt1       (gnt1),
        .memEn      (memEn),
        .memWe      (memWe),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .hostRvalid (hostRvalid)
    );

    dataBuffer buffer (
        .CLK   (CLK),
        .en    (memEn),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

endmodule

// File: verilog/dataBuffer.sv
`include "trivium_defines.svh"

module dataBuffer (
    input  logic            CLK,
    input  logic            en,
    input  logic            we,
    input  bufferPkg::addrT addr,
    input  bufferPkg::wordT wdata,
    output bufferPkg::wordT rdata
);

    bufferPkg::wordT mem [`BUF_DEPTH];   // Plaintext and ciphertext words

    // Single port, read data valid the cycle after the access
    always_ff @(posedge CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: verilog/bufferArbiter.sv
module bufferArbiter (
    input  logic            CLK,
    input  logic            RSTn,
    input  logic            hostWrite,
    input  logic            hostRead,
    input  bufferPkg::addrT hostAddr,
    input  bufferPkg::wordT hostWdata,
    input  logic            req0,
    input  logic            we0,
    input  bufferPkg::addrT addr0,
    input  bufferPkg::wordT wdata0,
    input  logic            req1,
    input  logic            we1,
    input  bufferPkg::addrT addr1,
    input  bufferPkg::wordT wdata1,
    output logic            gnt0,
    output logic            gnt1,
    output logic            memEn,
    output logic            memWe,
    output bufferPkg::addrT memAddr,
    output bufferPkg::wordT memWdata,
    output logic            hostRvalid
);

    bufferPkg::requesterT owner;        // This cycle's winner
    bufferPkg::requesterT lastWinner;   // Last engine granted
    bufferPkg::requesterT rdOwner;      // Who issued last cycle's read

    always_comb begin
        if (hostWrite || hostRead) begin
            owner = bufferPkg::HOST;
        end else if (req0 && req1) begin
            owner = (lastWinner == bufferPkg::ENG0) ? bufferPkg::ENG1 : bufferPkg::ENG0;
        end else if (req0) begin
            owner = bufferPkg::ENG0;
        end else if (req1) begin
            owner = bufferPkg::ENG1;
        end else begin
            owner = bufferPkg::NONE;
        end
    end

    always_comb begin
        memEn    = 1'b1;
        memWe    = 1'b0;
        memAddr  = '0;
        memWdata = '0;
        case (owner)
            bufferPkg::HOST: begin
                memWe    = hostWrite;   // Write wins a double strobe
                memAddr  = hostAddr;
                memWdata = hostWdata;
            end
            bufferPkg::ENG0: begin
                memWe    = we0;
                memAddr  = addr0;
                memWdata = wdata0;
            end
            bufferPkg::ENG1: begin
                memWe    = we1;
                memAddr  = addr1;
                memWdata = wdata1;
            end
            default: memEn = 1'b0;
        endcase
    end

    assign gnt0       = (owner == bufferPkg::ENG0);
    assign gnt1       = (owner == bufferPkg::ENG1);
    assign hostRvalid = (rdOwner == bufferPkg::HOST);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            lastWinner <= bufferPkg::NONE;
            rdOwner    <= bufferPkg::NONE;
        end else begin
            if (gnt0 || gnt1) begin
                lastWinner <= owner;
            end
            rdOwner <= (memEn && !memWe) ? owner : bufferPkg::NONE;
        end
    end

endmodule

// File: verilog/streamEngine.sv
`include "trivium_defines.svh"

module streamEngine (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              start,    // Job strobe
    input  logic [`KEY_W-1:0] key,
    input  logic [`KEY_W-1:0] iv,
    input  bufferPkg::addrT   base,     // First word of region
    input  logic [`ADDR_W:0]  words,    // Region length, 1 to BUF_DEPTH
    input  logic              gnt,
    input  bufferPkg::wordT   rdata,
    output logic              req,
    output logic              we,
    output bufferPkg::addrT   addr,
    output bufferPkg::wordT   wdata,
    output logic              busy,
    output logic              done
);

    localparam int BIT_W = $clog2(`WORD_W);

    triviumPkg::phaseT phase;
    logic              load;
    logic              stall;
    logic              ksBit;
    logic              ksValid;
    logic [BIT_W-1:0]  bitCnt;       // Bits gathered in current word
    logic              lastBit;
    logic              rdWait;       // Read granted, data due next cycle
    logic [`ADDR_W:0]  wordsLeft;
    bufferPkg::addrT   curAddr;
    bufferPkg::wordT   ksWord;
    bufferPkg::wordT   outWord;

    triviumCore core (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .load    (load),
        .stall   (stall),
        .key     (key),
        .iv      (iv),
        .ksBit   (ksBit),
        .ksValid (ksValid)
    );

    assign load    = start && (phase == triviumPkg::IDLE);   // Busy engines ignore start
    assign stall   = !(phase == triviumPkg::WARMUP || phase == triviumPkg::GATHER);
    assign lastBit = (bitCnt == BIT_W'(`WORD_W - 1));

    assign req   = ((phase == triviumPkg::READ) && !rdWait) || (phase == triviumPkg::WRITE);
    assign we    = (phase == triviumPkg::WRITE);
    assign addr  = curAddr;
    assign wdata = outWord;
    assign busy  = (phase != triviumPkg::IDLE);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            phase  <= triviumPkg::IDLE;
            rdWait <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (phase)
                triviumPkg::IDLE: begin
                    if (start) begin
                        phase <= triviumPkg::WARMUP;
                    end
                end
                triviumPkg::WARMUP: begin
                    if (ksValid) begin
                        phase <= triviumPkg::GATHER;   // First bit taken this cycle
                    end
                end
                triviumPkg::GATHER: begin
                    if (ksValid && lastBit) begin
                        phase <= triviumPkg::READ;
                    end
                end
                triviumPkg::READ: begin
                    if (rdWait) begin
                        rdWait <= 1'b0;
                        phase  <= triviumPkg::WRITE;
                    end else if (gnt) begin
                        rdWait <= 1'b1;
                    end
                end
                triviumPkg::WRITE: begin
                    if (gnt) begin
                        if (wordsLeft == 1) begin
                            phase <= triviumPkg::IDLE;
                            done  <= 1'b1;
                        end else begin
                            phase <= triviumPkg::GATHER;
                        end
                    end
                end
                default: phase <= triviumPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            curAddr   <= base;
            wordsLeft <= words;
            bitCnt    <= '0;
        end
        if (ksValid) begin
            ksWord <= {ksBit, ksWord[`WORD_W-1:1]};   // First bit lands in bit 0
            bitCnt <= bitCnt + 1'b1;                  // Wraps at word boundary
        end
        if ((phase == triviumPkg::READ) && rdWait) begin
            outWord <= rdata ^ ksWord;
        end
        if ((phase == triviumPkg::WRITE) && gnt) begin
            curAddr   <= curAddr + 1'b1;
            wordsLeft <= wordsLeft - 1'b1;
        end
    end

endmodule

// File: verilog/triviumCore.sv
`include "trivium_defines.svh"

module triviumCore (
    input  logic              CLK,
    input  logic              RSTn,
    input  logic              load,     // Start key/IV setup
    input  logic              stall,    // Freeze state and counter
    input  logic [`KEY_W-1:0] key,
    input  logic [`KEY_W-1:0] iv,
    output logic              ksBit,
    output logic              ksValid
);

    localparam int CNT_W = $clog2(`WARMUP_ROUNDS + 1);

    triviumPkg::stateT state;
    triviumPkg::stateT nextState;
    logic [CNT_W-1:0]  roundCnt;
    logic              running;    // Key loaded since reset
    logic              warm;       // Setup rounds finished
    logic              t1;
    logic              t2;
    logic              t3;
    logic              f1;
    logic              f2;
    logic              f3;

    // Swap byte order, lowest byte ends up on top
    function automatic logic [`KEY_W-1:0] byteReverse(input logic [`KEY_W-1:0] v);
        logic [`KEY_W-1:0] r;
        for (int i = 0; i < `KEY_W / 8; i++) begin
            r[8*i +: 8] = v[`KEY_W - 8*(i+1) +: 8];
        end
        return r;
    endfunction

    always_comb begin
        t1 = state[65] ^ state[92];      // Register A output taps
        t2 = state[161] ^ state[176];    // Register B output taps
        t3 = state[242] ^ state[287];    // Register C output taps
        f1 = t1 ^ (state[90] & state[91]) ^ state[170];
        f2 = t2 ^ (state[174] & state[175]) ^ state[263];
        f3 = t3 ^ (state[285] & state[286]) ^ state[68];
        nextState = {state[286:177], f2, state[175:93], f1, state[91:0], f3};
    end

    assign warm    = (roundCnt == CNT_W'(`WARMUP_ROUNDS));
    assign ksBit   = t1 ^ t2 ^ t3;
    assign ksValid = running && !stall && warm;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            running  <= 1'b0;
            roundCnt <= '0;
        end else if (load) begin
            running  <= 1'b1;
            roundCnt <= '0;
        end else if (running && !stall && !warm) begin
            roundCnt <= roundCnt + 1'b1;   // Saturates once warm
        end
    end

    // Load wins over stall so an idle engine can start a job
    always_ff @(posedge CLK) begin
        if (load) begin
            state <= {3'b111, 112'b0, byteReverse(iv), 13'b0, byteReverse(key)};
        end else if (running && !stall) begin
            state <= nextState;
        end
    end

endmodule

// File: verilog/bufferPkg.sv
`include "trivium_defines.svh"

package bufferPkg;

    typedef logic [`WORD_W-1:0] wordT;
    typedef logic [`ADDR_W-1:0] addrT;

    // Owner of a buffer cycle
    typedef enum logic [1:0] {
        NONE,
        HOST,
        ENG0,
        ENG1
    } requesterT;

endpackage

// File: verilog/triviumPkg.sv
package triviumPkg;

    // Three shift registers of 93, 84 and 111 bits
    localparam int STATE_W = 288;

    typedef logic [STATE_W-1:0] stateT;

    // Engine job phases
    typedef enum logic [2:0] {
        IDLE,       // Waiting for a job
        WARMUP,     // Core clocking through setup rounds
        GATHER,     // Collecting keystream bits into a word
        READ,       // Fetching the data word
        WRITE       // Writing back data XOR keystream
    } phaseT;

endpackage

// File: verilog/trivium_defines.svh
`ifndef TRIVIUM_DEFINES_SVH
`define TRIVIUM_DEFINES_SVH

// Trivium key and IV width, both 80 bits
`define KEY_W 80

// Rounds clocked after load before keystream is used
`define WARMUP_ROUNDS 1152

// Buffer word width, also keystream bits per word
`define WORD_W 32

// Shared word buffer geometry
`define BUF_DEPTH 64
`define ADDR_W 6

`endif
